// ==== common/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath width
`define RV_XLEN 32

// shift amount comes from the low bits of operand b
`define RV_SHAMT_W 5

// 32 architectural registers
`define RV_REG_AW 5

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SLTU = 4'b0110,
        ALU_SRL  = 4'b0111,
        ALU_SLL  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ   = 3'b000,
        BR_NE   = 3'b001,
        BR_LT   = 3'b010,
        BR_GE   = 3'b011,
        BR_LTU  = 3'b100,
        BR_GEU  = 3'b101,
        BR_NONE = 3'b111
    } br_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_U = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_fmt_e;

    // one instruction word, seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_u;

endpackage

`default_nettype wire

// ==== dv/int_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module int_core_tb;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_LINES    = 1000;
    localparam int IDLE_LIMIT   = 8;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        branch_taken;
    logic        illegal;

    int errors;
    int checks;
    bit timed_out;

    int_core UUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .pc_o           (pc),
        .wb_en_o        (wb_en),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .branch_taken_o (branch_taken),
        .illegal_o      (illegal)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // valid low with junk on the bus moves nothing
    task automatic insert_idle(input int n_idle);
        int          cycles;
        logic [31:0] pc_before;
        cycles    = 0;
        pc_before = pc;
        while (cycles < n_idle && !timed_out) begin
            @(negedge clk);
            instr_valid = 1'b0;
            instr       = $urandom;
            #(HALF_PERIOD - 1);
            check_value("wb_en_o", 32'(wb_en), 32'd0);
            check_value("branch_taken_o", 32'(branch_taken), 32'd0);
            check_value("illegal_o", 32'(illegal), 32'd0);
            @(posedge clk);
            #1;
            check_value("pc_o", pc, pc_before);
            cycles++;
            if (cycles > IDLE_LIMIT) begin
                timed_out = 1'b1;
                $display("idle wait ran past its cycle limit");
            end
        end
    endtask

    task automatic apply_instr(input logic [31:0] word, input logic [31:0] exp_wb_en,
                               input logic [31:0] exp_rd, input logic [31:0] exp_data,
                               input logic [31:0] exp_taken, input logic [31:0] exp_pc,
                               input logic [31:0] exp_illegal);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        // combinational outputs settle well before the edge
        #(HALF_PERIOD - 1);
        check_value("wb_en_o", 32'(wb_en), exp_wb_en);
        if (exp_wb_en != 0) begin
            check_value("wb_rd_o", 32'(wb_rd), exp_rd);
            check_value("wb_data_o", wb_data, exp_data);
        end
        check_value("branch_taken_o", 32'(branch_taken), exp_taken);
        check_value("illegal_o", 32'(illegal), exp_illegal);
        @(posedge clk);
        #1;
        check_value("pc_o", pc, exp_pc);
    endtask

    task automatic play_trace();
        int          fd;
        int          n_read;
        int          n_fields;
        int          line_cnt;
        int          n_instr;
        string       line;
        logic [31:0] word;
        logic [31:0] e_wb;
        logic [31:0] e_rd;
        logic [31:0] e_data;
        logic [31:0] e_taken;
        logic [31:0] e_pc;
        logic [31:0] e_ill;
        line_cnt = 0;
        n_instr  = 0;
        fd = $fopen("dv/int_core_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file dv/int_core_trace.txt");
        end else begin
            while (!$feof(fd) && line_cnt < MAX_LINES && !timed_out) begin
                n_read = $fgets(line, fd);
                line_cnt++;
                // comment and blank lines do not scan into seven fields
                n_fields = $sscanf(line, "%h %h %d %h %h %h %h",
                                   word, e_wb, e_rd, e_data, e_taken, e_pc, e_ill);
                if (n_read > 0 && n_fields == 7) begin
                    insert_idle(int'($urandom % 4));
                    apply_instr(word, e_wb, e_rd, e_data, e_taken, e_pc, e_ill);
                    n_instr++;
                end
            end
            $fclose(fd);
            if (line_cnt >= MAX_LINES) begin
                timed_out = 1'b1;
                $display("trace read did not reach the end of the file");
            end
            if (n_instr == 0) begin
                errors++;
                $display("the trace file held no instructions");
            end
        end
    endtask

    initial begin
        void'($urandom(32'hd08e_77cf));
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst_n = 1'b1;
        #(HALF_PERIOD - 1);
        check_value("pc_o", pc, `RV_RESET_PC);
        check_value("wb_en_o", 32'(wb_en), 32'd0);
        check_value("branch_taken_o", 32'(branch_taken), 32'd0);
        check_value("illegal_o", 32'(illegal), 32'd0);
        play_trace();
        @(negedge clk);
        instr_valid = 1'b0;
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/int_core_trace.txt ====
# instr    wb_en rd data     taken next_pc  illegal
# rd in decimal, all other columns in hex
00500093 1 1  00000005 0 00000004 0
ffd00113 1 2  fffffffd 0 00000008 0
002081b3 1 3  00000002 0 0000000c 0
40208233 1 4  00000008 0 00000010 0
0020f2b3 1 5  00000005 0 00000014 0
0020e333 1 6  fffffffd 0 00000018 0
0020c3b3 1 7  fffffff8 0 0000001c 0
00112433 1 8  00000001 0 00000020 0
001134b3 1 9  00000000 0 00000024 0
fff12513 1 10 00000001 0 00000028 0
fff0b593 1 11 00000001 0 0000002c 0
0f00c613 1 12 000000f5 0 00000030 0
7f017693 1 13 000007f0 0 00000034 0
ff00e713 1 14 fffffff5 0 00000038 0
00411793 1 15 ffffffd0 0 0000003c 0
01c15813 1 16 0000000f 0 00000040 0
40115893 1 17 fffffffe 0 00000044 0
02100913 1 18 00000021 0 00000048 0
012099b3 1 19 0000000a 0 0000004c 0
41215a33 1 20 fffffffe 0 00000050 0
01215ab3 1 21 7ffffffe 0 00000054 0
12345b37 1 22 12345000 0 00000058 0
00001b97 1 23 00001058 0 0000005c 0
00708013 0 0  00000000 0 00000060 0
00000c33 1 24 00000000 0 00000064 0
00108463 0 0  00000000 1 0000006c 0
00109463 0 0  00000000 0 00000070 0
00114463 0 0  00000000 1 00000078 0
00116463 0 0  00000000 0 0000007c 0
00115463 0 0  00000000 0 00000080 0
00117463 0 0  00000000 1 00000088 0
00209863 0 0  00000000 1 00000098 0
fe20dce3 0 0  00000000 1 00000090 0
0020e863 0 0  00000000 1 000000a0 0
00208463 0 0  00000000 0 000000a4 0
0020c463 0 0  00000000 0 000000a8 0
0020f463 0 0  00000000 0 000000ac 0
02000cef 1 25 000000b0 1 000000cc 0
00568d67 1 26 000000d0 1 000007f4 0
000c8067 0 0  00000000 1 000000b0 0
019d0db3 1 27 00000180 0 000000b4 0
fcdffe6f 1 28 000000b8 1 00000080 0
0000a083 0 0  00000000 0 00000080 1
021080b3 0 0  00000000 0 00000080 1
00002063 0 0  00000000 0 00000080 1
40109093 0 0  00000000 0 00000080 1
00008e93 1 29 00000005 0 00000084 0
00f60f33 1 30 000000c5 0 00000088 0
40100fb3 1 31 fffffffb 0 0000008c 0
004182b3 1 5  0000000a 0 00000090 0

// ==== exec/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module alu #(
    parameter int DATA_W = `RV_XLEN
) (
    input  wire [DATA_W-1:0]     src_a_i,
    input  wire [DATA_W-1:0]     src_b_i,
    input  wire rv_pkg::alu_op_e alu_op_i,
    input  wire rv_pkg::br_op_e  br_op_i,
    output logic [DATA_W-1:0]    result_o,
    output logic                 cond_o
);

    logic signed [DATA_W-1:0] a_s;
    logic signed [DATA_W-1:0] b_s;
    logic [`RV_SHAMT_W-1:0]   shamt;

    assign a_s = src_a_i;
    assign b_s = src_b_i;

    // upper bits of operand b are ignored for shifts
    assign shamt = src_b_i[`RV_SHAMT_W-1:0];

    // branch condition
    always_comb begin
        case (br_op_i)
            rv_pkg::BR_EQ: begin
                cond_o = (src_a_i == src_b_i);
            end
            rv_pkg::BR_NE: begin
                cond_o = (src_a_i != src_b_i);
            end
            rv_pkg::BR_LT: begin
                cond_o = (a_s < b_s);
            end
            rv_pkg::BR_GE: begin
                cond_o = (a_s >= b_s);
            end
            rv_pkg::BR_LTU: begin
                cond_o = (src_a_i < src_b_i);
            end
            rv_pkg::BR_GEU: begin
                cond_o = (src_a_i >= src_b_i);
            end
            default: begin
                cond_o = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD: begin
                result_o = src_a_i + src_b_i;
            end
            rv_pkg::ALU_SUB: begin
                result_o = src_a_i - src_b_i;
            end
            rv_pkg::ALU_AND: begin
                result_o = src_a_i & src_b_i;
            end
            rv_pkg::ALU_OR: begin
                result_o = src_a_i | src_b_i;
            end
            rv_pkg::ALU_XOR: begin
                result_o = src_a_i ^ src_b_i;
            end
            rv_pkg::ALU_SLT: begin
                result_o = {{(DATA_W-1){1'b0}}, (a_s < b_s)};
            end
            rv_pkg::ALU_SLTU: begin
                result_o = {{(DATA_W-1){1'b0}}, (src_a_i < src_b_i)};
            end
            rv_pkg::ALU_SRL: begin
                result_o = src_a_i >> shamt;
            end
            rv_pkg::ALU_SLL: begin
                result_o = src_a_i << shamt;
            end
            rv_pkg::ALU_SRA: begin
                // sign bit fills from the left
                result_o = a_s >>> shamt;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    // clean operands and a valid op code must never leave X on the result
    always_comb begin
        if (!$isunknown({alu_op_i, src_a_i, src_b_i})) begin
            a_result_known: assert final (!$isunknown(result_o))
                else $error("alu result has X bits for op %0d", alu_op_i);
        end
    end

endmodule

`default_nettype wire

// ==== exec/imm_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
    input  wire rv_pkg::rv_instr_u instr_i,
    input  wire rv_pkg::imm_fmt_e  fmt_i,
    output logic [31:0]            imm_o
);

    always_comb begin
        case (fmt_i)
            rv_pkg::IMM_I: begin
                imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
            end
            rv_pkg::IMM_U: begin
                // lui / auipc put the field in the upper bits
                imm_o = {instr_i.u.imm, 12'b0};
            end
            rv_pkg::IMM_B: begin
                imm_o = {
                    {19{instr_i.b.imm12}},
                    instr_i.b.imm12,
                    instr_i.b.imm11,
                    instr_i.b.imm10_5,
                    instr_i.b.imm4_1,
                    1'b0
                };
            end
            rv_pkg::IMM_J: begin
                imm_o = {
                    {11{instr_i.j.imm20}},
                    instr_i.j.imm20,
                    instr_i.j.imm19_12,
                    instr_i.j.imm11,
                    instr_i.j.imm10_1,
                    1'b0
                };
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run from the project root, judge by the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module int_core_tb \
    -Mdir obj_dir -o int_core_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/int_core_sim > sim.log 2>&1
cat sim.log

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module instr_decode (
    input  wire rv_pkg::rv_instr_u instr_i,
    input  wire                    valid_i,
    output logic [`RV_REG_AW-1:0]  rs1_o,
    output logic [`RV_REG_AW-1:0]  rs2_o,
    output logic [`RV_REG_AW-1:0]  rd_o,
    output logic                   wb_en_o,
    output rv_pkg::alu_op_e        alu_op_o,
    output rv_pkg::br_op_e         br_op_o,
    output rv_pkg::imm_fmt_e       imm_fmt_o,
    output logic                   src_a_pc_o,
    output logic                   src_a_zero_o,
    output logic                   src_b_imm_o,
    output logic                   is_jal_o,
    output logic                   is_jalr_o,
    output logic                   illegal_o
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;
    logic       writes_rd;
    logic       bad;

    assign rs1_o  = instr_i.r.rs1;
    assign rs2_o  = instr_i.r.rs2;
    assign rd_o   = instr_i.r.rd;
    assign funct7 = instr_i.r.funct7;
    assign funct3 = instr_i.r.funct3;

    assign f7_zero = (funct7 == 7'b0000000);
    // only bit 5 set selects sub and sra
    assign f7_alt  = (funct7 == 7'b0100000);

    always_comb begin
        alu_op_o     = rv_pkg::ALU_ADD;
        br_op_o      = rv_pkg::BR_NONE;
        imm_fmt_o    = rv_pkg::IMM_I;
        src_a_pc_o   = 1'b0;
        src_a_zero_o = 1'b0;
        src_b_imm_o  = 1'b0;
        is_jal_o     = 1'b0;
        is_jalr_o    = 1'b0;
        writes_rd    = 1'b0;
        bad          = 1'b0;
        case (instr_i.r.opcode)
            rv_pkg::OPC_OP: begin
                writes_rd = 1'b1;
                bad = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
                case (funct3)
                    3'b000: alu_op_o = f7_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: alu_op_o = rv_pkg::ALU_SLL;
                    3'b010: alu_op_o = rv_pkg::ALU_SLT;
                    3'b011: alu_op_o = rv_pkg::ALU_SLTU;
                    3'b100: alu_op_o = rv_pkg::ALU_XOR;
                    3'b101: alu_op_o = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110: alu_op_o = rv_pkg::ALU_OR;
                    default: alu_op_o = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                writes_rd   = 1'b1;
                src_b_imm_o = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = rv_pkg::ALU_ADD;
                    3'b010: alu_op_o = rv_pkg::ALU_SLT;
                    3'b011: alu_op_o = rv_pkg::ALU_SLTU;
                    3'b100: alu_op_o = rv_pkg::ALU_XOR;
                    3'b110: alu_op_o = rv_pkg::ALU_OR;
                    3'b111: alu_op_o = rv_pkg::ALU_AND;
                    3'b001: begin
                        alu_op_o = rv_pkg::ALU_SLL;
                        bad      = !f7_zero;
                    end
                    default: begin
                        alu_op_o = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        bad      = !(f7_zero || f7_alt);
                    end
                endcase
            end
            rv_pkg::OPC_LUI: begin
                writes_rd    = 1'b1;
                imm_fmt_o    = rv_pkg::IMM_U;
                src_a_zero_o = 1'b1;
                src_b_imm_o  = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                writes_rd   = 1'b1;
                imm_fmt_o   = rv_pkg::IMM_U;
                src_a_pc_o  = 1'b1;
                src_b_imm_o = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                imm_fmt_o = rv_pkg::IMM_B;
                case (funct3)
                    3'b000: br_op_o = rv_pkg::BR_EQ;
                    3'b001: br_op_o = rv_pkg::BR_NE;
                    3'b100: br_op_o = rv_pkg::BR_LT;
                    3'b101: br_op_o = rv_pkg::BR_GE;
                    3'b110: br_op_o = rv_pkg::BR_LTU;
                    3'b111: br_op_o = rv_pkg::BR_GEU;
                    default: bad = 1'b1;
                endcase
            end
            rv_pkg::OPC_JAL: begin
                writes_rd = 1'b1;
                imm_fmt_o = rv_pkg::IMM_J;
                is_jal_o  = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                // target rs1 + imm comes out of the alu
                writes_rd   = 1'b1;
                src_b_imm_o = 1'b1;
                is_jalr_o   = 1'b1;
                bad         = (funct3 != 3'b000);
            end
            default: begin
                bad = 1'b1;
            end
        endcase
    end

    assign illegal_o = valid_i && bad;
    assign wb_en_o   = valid_i && !bad && writes_rd && (instr_i.r.rd != '0);

endmodule

`default_nettype wire

// ==== source/int_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module int_core (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   instr_valid_i,
    input  wire [31:0]            instr_i,
    output logic [`RV_XLEN-1:0]   pc_o,
    output logic                  wb_en_o,
    output logic [`RV_REG_AW-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]   wb_data_o,
    output logic                  branch_taken_o,
    output logic                  illegal_o
);

    rv_pkg::rv_instr_u    instr;
    rv_pkg::alu_op_e      alu_op;
    rv_pkg::br_op_e       br_op;
    rv_pkg::imm_fmt_e     imm_fmt;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic                 src_a_pc;
    logic                 src_a_zero;
    logic                 src_b_imm;
    logic                 is_jal;
    logic                 is_jalr;
    logic                 is_branch;
    logic [`RV_XLEN-1:0]  imm;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic [`RV_XLEN-1:0]  src_a;
    logic [`RV_XLEN-1:0]  src_b;
    logic [`RV_XLEN-1:0]  alu_result;
    logic                 alu_cond;
    logic [`RV_XLEN-1:0]  pc_plus4;

    assign instr = instr_i;

    instr_decode u_decode (
        .instr_i      (instr),
        .valid_i      (instr_valid_i),
        .rs1_o        (rs1_addr),
        .rs2_o        (rs2_addr),
        .rd_o         (wb_rd_o),
        .wb_en_o      (wb_en_o),
        .alu_op_o     (alu_op),
        .br_op_o      (br_op),
        .imm_fmt_o    (imm_fmt),
        .src_a_pc_o   (src_a_pc),
        .src_a_zero_o (src_a_zero),
        .src_b_imm_o  (src_b_imm),
        .is_jal_o     (is_jal),
        .is_jalr_o    (is_jalr),
        .illegal_o    (illegal_o)
    );

    imm_gen u_imm_gen (
        .instr_i (instr),
        .fmt_i   (imm_fmt),
        .imm_o   (imm)
    );

    reg_file #(.DATA_W(`RV_XLEN)) u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wr_addr_i  (wb_rd_o),
        .wr_en_i    (wb_en_o),
        .wr_data_i  (wb_data_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // lui adds its immediate to zero, auipc to the pc
    assign src_a = src_a_zero ? '0 : (src_a_pc ? pc_o : rs1_data);
    assign src_b = src_b_imm ? imm : rs2_data;

    alu #(.DATA_W(`RV_XLEN)) u_alu (
        .src_a_i  (src_a),
        .src_b_i  (src_b),
        .alu_op_i (alu_op),
        .br_op_i  (br_op),
        .result_o (alu_result),
        .cond_o   (alu_cond)
    );

    assign is_branch = (br_op != rv_pkg::BR_NONE);

    pc_unit u_pc_unit (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (instr_valid_i),
        .branch_cond_i (alu_cond),
        .is_branch_i   (is_branch),
        .is_jal_i      (is_jal),
        .is_jalr_i     (is_jalr),
        .illegal_i     (illegal_o),
        .imm_i         (imm),
        .jalr_target_i (alu_result),
        .pc_o          (pc_o),
        .pc_plus4_o    (pc_plus4),
        .taken_o       (branch_taken_o)
    );

    // jumps link the return address
    assign wb_data_o = (is_jal || is_jalr) ? pc_plus4 : alu_result;

endmodule

`default_nettype wire

// ==== source/pc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module pc_unit (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  wire                 valid_i,
    input  wire                 branch_cond_i,
    input  wire                 is_branch_i,
    input  wire                 is_jal_i,
    input  wire                 is_jalr_i,
    input  wire                 illegal_i,
    input  wire [`RV_XLEN-1:0]  imm_i,
    input  wire [`RV_XLEN-1:0]  jalr_target_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic [`RV_XLEN-1:0] pc_plus4_o,
    output logic                taken_o
);

    logic                fire;
    logic                rel_jump;
    logic [`RV_XLEN-1:0] pc_rel;
    logic [`RV_XLEN-1:0] pc_next;

    assign fire       = valid_i && !illegal_i;
    assign rel_jump   = is_jal_i || (is_branch_i && branch_cond_i);
    assign pc_plus4_o = pc_o + `RV_XLEN'd4;
    assign pc_rel     = pc_o + imm_i;
    assign taken_o    = fire && (rel_jump || is_jalr_i);

    always_comb begin
        if (is_jalr_i) begin
            // jalr clears bit 0 of the target
            pc_next = {jalr_target_i[`RV_XLEN-1:1], 1'b0};
        end else if (rel_jump) begin
            pc_next = pc_rel;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= `RV_RESET_PC;
        end else if (fire) begin
            pc_o <= pc_next;
        end
    end

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i) pc_o[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc_o);

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module reg_file #(
    parameter int DATA_W = `RV_XLEN
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire [`RV_REG_AW-1:0]  rs1_addr_i,
    input  wire [`RV_REG_AW-1:0]  rs2_addr_i,
    input  wire [`RV_REG_AW-1:0]  wr_addr_i,
    input  wire                   wr_en_i,
    input  wire [DATA_W-1:0]      wr_data_i,
    output logic [DATA_W-1:0]     rs1_data_o,
    output logic [DATA_W-1:0]     rs2_data_o
);

    localparam int DEPTH = 1 << `RV_REG_AW;

    logic [DATA_W-1:0] regs [DEPTH];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 is hard-wired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i) regs[0] == '0)
        else $error("register x0 was written");

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/rv_pkg.sv
exec/alu.sv
exec/imm_gen.sv
source/instr_decode.sv
source/reg_file.sv
source/pc_unit.sv
source/int_core.sv
dv/int_core_tb.sv
